// ==== hdl/mac_rgmii_pkg.sv ====
//----------------------------------------------------------------------
// mac rgmii receive package
// shared widths, crc-32 constants, speed codes, received byte views
//----------------------------------------------------------------------
package mac_rgmii_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int DATA_W   = 8;   // one rgmii byte per clock
    localparam int STATUS_W = 4;   // in-band status nibble
    localparam int CRC_W    = 32;

    // ------------------------------------------------------------------
    // crc-32, ethernet, lsb first
    // ------------------------------------------------------------------
    // reflected form of 0x04c11db7
    localparam logic [CRC_W-1:0] CRC_POLY    = 32'hEDB8_8320;
    localparam logic [CRC_W-1:0] CRC_INIT    = 32'hFFFF_FFFF;  // all ones preset
    // register value after data plus a correct fcs, no final inversion
    localparam logic [CRC_W-1:0] CRC_RESIDUE = 32'hDEBB_20E3;

    // ------------------------------------------------------------------
    // in-band speed codes, as sent by the phy in the interframe gap
    // ------------------------------------------------------------------
    localparam logic [1:0] SPEED_10   = 2'b00;  // 2.5 MHz rx clock
    localparam logic [1:0] SPEED_100  = 2'b01;  // 25 MHz rx clock
    localparam logic [1:0] SPEED_1000 = 2'b10;  // 125 MHz rx clock
    // 2'b11 reserved

    // received byte
    // payload bytes are read as data, idle bytes as the status word
    typedef union packed {
        logic [DATA_W-1:0] data;           // frame byte
        struct packed {
            logic [DATA_W-STATUS_W-1:0] unused;  // repeats lower nibble on the wire
            logic                       duplex;  // 1 = full duplex
            logic [1:0]                 speed;   // see SPEED_* codes
            logic                       link;    // lsb, 1 = link up
        } status;
    } rx_byte_t;

endpackage

// ==== hdl/rx_frame_tracker.sv ====
//----------------------------------------------------------------------
// receive frame tracker
// strips preamble/sfd, marks first and last payload byte,
// latches the in-band link status during idle
//----------------------------------------------------------------------
`timescale 1ns/1ps

module rx_frame_tracker #(
    parameter int PREAMBLE_LEN = 8    // preamble plus sfd bytes
) (
    input  logic                            mac_rx_clk,
    input  logic                            reset_i,

    // byte stream from the input ddr stage
    input  mac_rgmii_pkg::rx_byte_t         rx_data_i,
    input  logic                            rx_dv_i,
    input  logic                            rx_err_i,

    // delayed stream to the output stage
    output logic [mac_rgmii_pkg::DATA_W-1:0] trk_data_o,
    output logic                            trk_valid_o,
    output logic                            trk_sof_o,
    output logic                            trk_eof_o,

    // payload bytes to the crc checker
    output logic [mac_rgmii_pkg::DATA_W-1:0] pay_byte_o,
    output logic                            pay_en_o,
    output logic                            pay_first_o,

    // in-band status
    output logic                            link_up_o,
    output logic [1:0]                      speed_o,
    output logic                            full_duplex_o
);

    localparam int CNT_W = 16;

    logic [CNT_W-1:0]                 byte_cnt;   // bytes seen in current dv run
    logic [mac_rgmii_pkg::DATA_W-1:0] data_q;     // byte delayed one clock
    logic                             pay_q;      // delayed byte is payload
    logic                             first_q;    // delayed byte is first payload

    // ------------------------------------------------------------------
    // byte counter, cleared in the gap
    // ------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        if (reset_i || !rx_dv_i) begin
            byte_cnt <= '0;
        end else if (byte_cnt != '1) begin       // saturate on jumbo runs
            byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // one stage delay, lets the next dv tell us the last byte
    // ------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        data_q <= rx_data_i.data;                // payload, no reset
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            pay_q   <= 1'b0;
            first_q <= 1'b0;
        end else begin
            // index PREAMBLE_LEN onwards is frame data
            pay_q   <= rx_dv_i && (byte_cnt >= CNT_W'(PREAMBLE_LEN));
            first_q <= rx_dv_i && (byte_cnt == CNT_W'(PREAMBLE_LEN));
        end
    end

    assign trk_data_o  = data_q;
    assign trk_valid_o = pay_q;
    assign trk_sof_o   = first_q;
    assign trk_eof_o   = pay_q && !rx_dv_i;      // dv just dropped

    // crc side sees the same delayed byte
    assign pay_byte_o  = data_q;
    assign pay_en_o    = pay_q;
    assign pay_first_o = first_q;                // restarts the crc

    // ------------------------------------------------------------------
    // in-band status, only on clean idle bytes
    // ------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            link_up_o     <= 1'b0;
            speed_o       <= mac_rgmii_pkg::SPEED_10;
            full_duplex_o <= 1'b0;
        end else if (!rx_dv_i && !rx_err_i) begin
            link_up_o     <= rx_data_i.status.link;
            full_duplex_o <= rx_data_i.status.duplex;
            case (rx_data_i.status.speed)
                mac_rgmii_pkg::SPEED_10,
                mac_rgmii_pkg::SPEED_100,
                mac_rgmii_pkg::SPEED_1000: speed_o <= rx_data_i.status.speed;
                default:                   speed_o <= speed_o;  // reserved code, hold
            endcase
        end
    end

endmodule

// ==== hdl/rx_crc_checker.sv ====
//----------------------------------------------------------------------
// receive crc-32 checker
// runs the reflected crc over payload and fcs, flags the residue
//----------------------------------------------------------------------
`timescale 1ns/1ps

module rx_crc_checker (
    input  logic                             mac_rx_clk,
    input  logic                             reset_i,

    input  logic [mac_rgmii_pkg::DATA_W-1:0] pay_byte_i,
    input  logic                             pay_en_i,     // one per payload byte
    input  logic                             pay_first_i,  // first byte of frame

    output logic                             crc_match_o
);

    logic [mac_rgmii_pkg::CRC_W-1:0] crc_q;    // running crc, no final inversion
    logic [mac_rgmii_pkg::CRC_W-1:0] crc_base; // preset or running value
    logic [mac_rgmii_pkg::CRC_W-1:0] crc_next;

    // ------------------------------------------------------------------
    // one byte step, lsb of the byte goes first
    // ------------------------------------------------------------------
    function automatic logic [mac_rgmii_pkg::CRC_W-1:0] crc_byte(
        input logic [mac_rgmii_pkg::CRC_W-1:0]  crc_in,
        input logic [mac_rgmii_pkg::DATA_W-1:0] data_in
    );
        logic [mac_rgmii_pkg::CRC_W-1:0] c;
        logic                            fb;
        c = crc_in;
        for (int i = 0; i < mac_rgmii_pkg::DATA_W; i++) begin
            fb = c[0] ^ data_in[i];                         // feedback bit
            c  = (c >> 1) ^ (mac_rgmii_pkg::CRC_POLY & {mac_rgmii_pkg::CRC_W{fb}});
        end
        return c;
    endfunction

    // new frame starts from the preset, not from the old frame
    assign crc_base = pay_first_i ? mac_rgmii_pkg::CRC_INIT : crc_q;
    assign crc_next = crc_byte(crc_base, pay_byte_i);

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            crc_q <= mac_rgmii_pkg::CRC_INIT;
        end else if (pay_en_i) begin
            crc_q <= crc_next;
        end
    end

    // fcs included in the run, so a good frame leaves the residue
    assign crc_match_o = (crc_q == mac_rgmii_pkg::CRC_RESIDUE);

endmodule

// ==== hdl/rx_stream_output.sv ====
//----------------------------------------------------------------------
// receive stream output stage
// registers the frame stream and qualifies crc-good with eof
//----------------------------------------------------------------------
`timescale 1ns/1ps

module rx_stream_output (
    input  logic                             mac_rx_clk,
    input  logic                             reset_i,

    // stream from the frame tracker
    input  logic [mac_rgmii_pkg::DATA_W-1:0] trk_data_i,
    input  logic                             trk_valid_i,
    input  logic                             trk_sof_i,
    input  logic                             trk_eof_i,

    // from the crc checker
    input  logic                             crc_match_i,

    // user side
    output logic [mac_rgmii_pkg::DATA_W-1:0] mac_rx_data_o,
    output logic                             mac_rx_valid_o,
    output logic                             mac_rx_sof_o,
    output logic                             mac_rx_eof_o,
    output logic                             mac_rx_crc_good_o
);

    // ------------------------------------------------------------------
    // stream register
    // ------------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        mac_rx_data_o <= trk_data_i;             // data, no reset
    end

    always_ff @(posedge mac_rx_clk) begin
        if (reset_i) begin
            mac_rx_valid_o <= 1'b0;
            mac_rx_sof_o   <= 1'b0;
            mac_rx_eof_o   <= 1'b0;
        end else begin
            mac_rx_valid_o <= trk_valid_i;       // level, sof through eof
            mac_rx_sof_o   <= trk_sof_i;
            mac_rx_eof_o   <= trk_eof_i;
        end
    end

    // ------------------------------------------------------------------
    // crc result
    // ------------------------------------------------------------------
    // the checker register takes in the last byte on the same edge that
    // loads eof here, so both line up in the eof cycle
    assign mac_rx_crc_good_o = mac_rx_eof_o & crc_match_i;

endmodule

// ==== hdl/mac_rgmii_rx.sv ====
//----------------------------------------------------------------------
// 1g rgmii mac, receive channel
// byte stream in, framed stream with crc check and link status out
//----------------------------------------------------------------------
`timescale 1ns/1ps

module mac_rgmii_rx #(
    parameter int PREAMBLE_LEN = 8            // 7 x 0x55 plus 0xd5
) (
    input  logic                             mac_rx_clk,
    input  logic                             reset_i,

    // byte stream from the ddr input stage
    input  logic [mac_rgmii_pkg::DATA_W-1:0] rx_data_i,
    input  logic                             rx_dv_i,
    input  logic                             rx_err_i,

    // receive stream, logic side
    output logic [mac_rgmii_pkg::DATA_W-1:0] mac_rx_data_o,
    output logic                             mac_rx_valid_o,
    output logic                             mac_rx_sof_o,
    output logic                             mac_rx_eof_o,
    output logic                             mac_rx_crc_good_o,

    // in-band status
    output logic                             link_up_o,
    output logic [1:0]                       speed_o,
    output logic                             full_duplex_o
);

    // tracker to output stage
    logic [mac_rgmii_pkg::DATA_W-1:0] trk_data;
    logic                             trk_valid;
    logic                             trk_sof;
    logic                             trk_eof;

    // tracker to crc checker
    logic [mac_rgmii_pkg::DATA_W-1:0] pay_byte;
    logic                             pay_en;
    logic                             pay_first;

    logic                             crc_match;

    // ------------------------------------------------------------------
    // frame tracker
    // ------------------------------------------------------------------
    rx_frame_tracker #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) i_rx_frame_tracker (
        .mac_rx_clk    (mac_rx_clk),
        .reset_i       (reset_i),
        .rx_data_i     (rx_data_i),
        .rx_dv_i       (rx_dv_i),
        .rx_err_i      (rx_err_i),
        .trk_data_o    (trk_data),
        .trk_valid_o   (trk_valid),
        .trk_sof_o     (trk_sof),
        .trk_eof_o     (trk_eof),
        .pay_byte_o    (pay_byte),
        .pay_en_o      (pay_en),
        .pay_first_o   (pay_first),
        .link_up_o     (link_up_o),
        .speed_o       (speed_o),
        .full_duplex_o (full_duplex_o)
    );

    // crc checker, beside the stream path
    rx_crc_checker i_rx_crc_checker (
        .mac_rx_clk  (mac_rx_clk),
        .reset_i     (reset_i),
        .pay_byte_i  (pay_byte),
        .pay_en_i    (pay_en),
        .pay_first_i (pay_first),
        .crc_match_o (crc_match)
    );

    // ------------------------------------------------------------------
    // output stage
    // ------------------------------------------------------------------
    rx_stream_output i_rx_stream_output (
        .mac_rx_clk        (mac_rx_clk),
        .reset_i           (reset_i),
        .trk_data_i        (trk_data),
        .trk_valid_i       (trk_valid),
        .trk_sof_i         (trk_sof),
        .trk_eof_i         (trk_eof),
        .crc_match_i       (crc_match),
        .mac_rx_data_o     (mac_rx_data_o),
        .mac_rx_valid_o    (mac_rx_valid_o),
        .mac_rx_sof_o      (mac_rx_sof_o),
        .mac_rx_eof_o      (mac_rx_eof_o),
        .mac_rx_crc_good_o (mac_rx_crc_good_o)
    );

endmodule

// ==== test/tb_mac_rgmii_rx.sv ====
//----------------------------------------------------------------------
// testbench for the rgmii receive channel
// frames from the stimulus file, output bytes checked against a queue
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_mac_rgmii_rx;

    localparam int PREAMBLE_LEN = 8;
    localparam int FIELDS       = 8;    // words per stimulus line
    localparam int MAX_LINES    = 32;
    localparam int MARGIN       = 64;   // reset, drain and slack cycles

    logic        mac_rx_clk;
    logic        reset_i;
    logic [7:0]  rx_data_i;
    logic        rx_dv_i;
    logic        rx_err_i;
    logic [7:0]  mac_rx_data_o;
    logic        mac_rx_valid_o;
    logic        mac_rx_sof_o;
    logic        mac_rx_eof_o;
    logic        mac_rx_crc_good_o;
    logic        link_up_o;
    logic [1:0]  speed_o;
    logic        full_duplex_o;

    logic [15:0] stim_mem [0:FIELDS*MAX_LINES-1];
    logic [63:0] exp_q [$];   // due cycle, frame, pad, crc_good, eof, sof, data
    logic [31:0] rng_state;
    int          cyc          = 0;
    int          limit_cycles = 0;
    int          eof_seen     = 0;

    mac_rgmii_rx #(
        .PREAMBLE_LEN (PREAMBLE_LEN)
    ) i_mac_rgmii_rx (
        .mac_rx_clk        (mac_rx_clk),
        .reset_i           (reset_i),
        .rx_data_i         (rx_data_i),
        .rx_dv_i           (rx_dv_i),
        .rx_err_i          (rx_err_i),
        .mac_rx_data_o     (mac_rx_data_o),
        .mac_rx_valid_o    (mac_rx_valid_o),
        .mac_rx_sof_o      (mac_rx_sof_o),
        .mac_rx_eof_o      (mac_rx_eof_o),
        .mac_rx_crc_good_o (mac_rx_crc_good_o),
        .link_up_o         (link_up_o),
        .speed_o           (speed_o),
        .full_duplex_o     (full_duplex_o)
    );

    initial begin
        mac_rx_clk = 1'b0;
        forever #10 mac_rx_clk = ~mac_rx_clk;   // 50 MHz
    end

    always @(posedge mac_rx_clk) begin
        cyc <= cyc + 1;                         // read at negedge, stable there
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp_val, input logic [31:0] act_val);
        abort_run($sformatf("Fail %s %s: expected 0x%0h actual 0x%0h",
                            name, field, exp_val, act_val));
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ethernet crc, one byte lsb first
    function automatic logic [31:0] crc_add_byte(input logic [31:0] crc,
                                                 input logic [7:0]  b);
        logic [31:0] r;
        r = crc;
        for (int k = 0; k < 8; k++) begin
            if (r[0] != b[k]) begin
                r = (r >> 1) ^ mac_rgmii_pkg::CRC_POLY;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    function automatic string speed_name(input logic [1:0] code);
        case (code)
            mac_rgmii_pkg::SPEED_10:   return "10M";
            mac_rgmii_pkg::SPEED_100:  return "100M";
            mac_rgmii_pkg::SPEED_1000: return "1G";
            default:                   return "reserved";
        endcase
    endfunction

    task automatic check_status(input string name, input logic exp_link,
                                input logic [1:0] exp_speed, input logic exp_dup);
        assert (link_up_o == exp_link)
            else report_mismatch(name, "link", 32'(exp_link), 32'(link_up_o));
        assert (speed_o == exp_speed)
            else abort_run($sformatf("Fail %s speed: expected %s actual %s",
                                     name, speed_name(exp_speed), speed_name(speed_o)));
        assert (full_duplex_o == exp_dup)
            else report_mismatch(name, "duplex", 32'(exp_dup), 32'(full_duplex_o));
    endtask

    // ------------------------------------------------------------------
    // output monitor, samples at negedge
    // ------------------------------------------------------------------
    always @(negedge mac_rx_clk) begin
        logic [63:0] ent;
        string       name;
        if (!reset_i) begin
            if (mac_rx_valid_o) begin
                assert (exp_q.size() != 0) else abort_run("valid output with no byte expected");
                ent  = exp_q.pop_front();
                name = $sformatf("frame %0d", ent[31:16]);
                assert (cyc == int'(ent[63:32]))
                    else report_mismatch(name, "cycle", ent[63:32], 32'(cyc));
                assert (mac_rx_data_o == ent[7:0])
                    else report_mismatch(name, "data", 32'(ent[7:0]), 32'(mac_rx_data_o));
                assert (mac_rx_sof_o == ent[8])
                    else report_mismatch(name, "sof", 32'(ent[8]), 32'(mac_rx_sof_o));
                assert (mac_rx_eof_o == ent[9])
                    else report_mismatch(name, "eof", 32'(ent[9]), 32'(mac_rx_eof_o));
                assert (mac_rx_crc_good_o == ent[10])
                    else report_mismatch(name, "crc_good", 32'(ent[10]),
                                         32'(mac_rx_crc_good_o));
                if (mac_rx_eof_o) begin
                    eof_seen = eof_seen + 1;
                end
            end else begin
                assert (!mac_rx_sof_o && !mac_rx_eof_o && !mac_rx_crc_good_o)
                    else abort_run("sof, eof or crc_good high while valid is low");
                if (exp_q.size() != 0) begin        // oldest byte overdue
                    assert (int'(exp_q[0][63:32]) > cyc)
                        else abort_run($sformatf("frame %0d byte missing at cycle %0d",
                                                 exp_q[0][31:16], cyc));
                end
            end
        end
    end

    // watchdog, armed once the stimulus is loaded
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge mac_rx_clk);
        abort_run($sformatf("timeout, run did not end within %0d clock cycles", limit_cycles));
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        int          base;
        int          n_lines;
        int          limit;
        int          want_frames;
        int          idle_len;
        int          pay_len;
        int          mode;
        int          run_len;
        logic [3:0]  nib;
        logic        exp_crc;
        logic        exp_link;
        logic [1:0]  exp_speed;
        logic        exp_dup;
        logic [31:0] crc;
        logic [7:0]  run_q [$];
        string       name;

        reset_i   = 1'b1;
        rx_data_i = 8'hFF;
        rx_dv_i   = 1'b0;
        rx_err_i  = 1'b1;                       // false carrier, status must ignore it
        rng_state = 32'd83763;
        nib       = 4'h0;
        $readmemh("test/mac_rx_stimulus.txt", stim_mem);

        n_lines     = 0;
        limit       = MARGIN;
        want_frames = 0;
        while (n_lines < MAX_LINES && stim_mem[n_lines*FIELDS] != 16'hFFFF) begin
            base  = n_lines * FIELDS;
            limit = limit + int'(stim_mem[base+1]) + int'(stim_mem[base+2]) + PREAMBLE_LEN + 4;
            if (stim_mem[base+3] != 16'd2) begin
                want_frames++;
            end
            n_lines++;
        end
        if (n_lines == 0) begin
            abort_run("stimulus file holds no frame lines");
        end
        limit_cycles = limit;

        repeat (3) @(negedge mac_rx_clk);
        reset_i = 1'b0;
        for (int i = 0; i < 3; i++) begin       // reset values hold through error idles
            @(negedge mac_rx_clk);
            assert (!mac_rx_valid_o && !mac_rx_sof_o && !mac_rx_eof_o && !mac_rx_crc_good_o)
                else abort_run("stream outputs active after reset");
            check_status("after reset", 1'b0, mac_rgmii_pkg::SPEED_10, 1'b0);
        end

        for (int f = 0; f < n_lines; f++) begin
            base      = f * FIELDS;
            nib       = stim_mem[base][3:0];
            idle_len  = int'(stim_mem[base+1]);
            pay_len   = int'(stim_mem[base+2]);
            mode      = int'(stim_mem[base+3]);
            exp_crc   = stim_mem[base+4][0];
            exp_link  = stim_mem[base+5][0];
            exp_speed = stim_mem[base+6][1:0];
            exp_dup   = stim_mem[base+7][0];
            name      = $sformatf("frame %0d", f);

            // gap, last cycle carries an error level when there is room
            for (int i = 0; i < idle_len; i++) begin
                @(negedge mac_rx_clk);
                rx_dv_i = 1'b0;
                if (idle_len > 1 && i == idle_len - 1) begin
                    rx_err_i  = 1'b1;
                    rx_data_i = {~nib, ~nib};
                end else begin
                    rx_err_i  = 1'b0;
                    rx_data_i = {nib, nib};     // status nibble repeated
                end
            end

            run_q.delete();
            if (mode == 2) begin                // short run, preamble bytes only
                for (int j = 0; j < pay_len; j++) begin
                    run_q.push_back((j == PREAMBLE_LEN - 1) ? 8'hD5 : 8'h55);
                end
            end else begin
                for (int j = 0; j < PREAMBLE_LEN - 1; j++) begin
                    run_q.push_back(8'h55);
                end
                run_q.push_back(8'hD5);         // sfd
                crc = mac_rgmii_pkg::CRC_INIT;
                for (int j = 0; j < pay_len; j++) begin
                    rng_state = lcg_next(rng_state);
                    run_q.push_back(rng_state[23:16]);
                    crc = crc_add_byte(crc, rng_state[23:16]);
                end
                crc = ~crc;
                if (mode == 1) begin
                    crc[f % 32] = ~crc[f % 32];  // single bit error
                end
                for (int k = 0; k < 4; k++) begin
                    run_q.push_back(crc[8*k +: 8]);  // fcs, low byte first
                end
            end

            run_len = run_q.size();
            for (int j = 0; j < run_len; j++) begin
                @(negedge mac_rx_clk);
                if (j == 0) begin
                    check_status(name, exp_link, exp_speed, exp_dup);
                end
                rx_dv_i   = 1'b1;
                rx_err_i  = 1'b0;
                rx_data_i = run_q[j];
                if (mode != 2 && j >= PREAMBLE_LEN) begin
                    exp_q.push_back({32'(cyc + 2), 16'(f), 5'd0,
                                     exp_crc && (j == run_len - 1),
                                     (j == run_len - 1), (j == PREAMBLE_LEN), run_q[j]});
                end
            end
        end

        @(negedge mac_rx_clk);
        rx_dv_i   = 1'b0;
        rx_err_i  = 1'b0;
        rx_data_i = {nib, nib};
        while (exp_q.size() != 0) begin
            @(negedge mac_rx_clk);
        end
        repeat (4) @(negedge mac_rx_clk);       // no stray output after the last frame

        if (eof_seen == want_frames) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run($sformatf("Fail frame count: expected %0d actual %0d",
                                want_frames, eof_seen));
        end
    end

endmodule

// ==== mac_rgmii_rx.f ====
hdl/mac_rgmii_pkg.sv
hdl/rx_frame_tracker.sv
hdl/rx_crc_checker.sv
hdl/rx_stream_output.sv
hdl/mac_rgmii_rx.sv
test/tb_mac_rgmii_rx.sv

// ==== Makefile ====
# verilator build and run of the rgmii receive channel testbench

TOP = tb_mac_rgmii_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f mac_rgmii_rx.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/mac_rx_stimulus.txt ====
// columns, hex: status idle_len pay_len fcs_mode exp_crc_good exp_link exp_speed exp_duplex
// fcs_mode 0 correct, 1 one bit flipped, 2 short run of pay_len preamble bytes only
d 0c 2e 0 1 1 2 1  // min size frame, 1G full duplex
d 01 2e 0 1 1 2 1  // one cycle gap
d 01 3c 1 0 1 2 1
b 05 40 0 1 1 1 1
3 04 01 0 1 1 1 0  // single payload byte
3 01 08 2 0 1 1 0  // preamble and sfd only
3 01 2e 0 1 1 1 0
5 03 07 2 0 1 2 0
5 02 00 0 1 1 2 0  // fcs bytes only
f 06 20 0 1 1 2 1  // reserved speed, holds 1G
9 02 2e 1 0 1 0 1
1 01 01 2 0 1 0 0
0 08 2e 0 1 0 0 0  // link down
4 02 2e 0 1 0 2 0
7 03 10 0 1 1 2 0
e 02 2e 1 0 0 2 1
b 0a 5dc 0 1 1 1 1 // full length frame
b 01 80 1 0 1 1 1
5 01 2e 0 1 1 2 0
5 01 2e 0 1 1 2 0
5 01 04 2 0 1 2 0
5 01 2e 1 0 1 2 0
d 03 2e 0 1 1 2 1
9 02 11 0 1 1 0 1
// end marker
ffff 0 0 0 0 0 0 0
